/* hw/pyr_alu.sv */
// Integer ALU for the execute stage.
// Purely combinational; the compare flags always come from a - b so
// branch evaluation can use them whatever operation is selected.

`timescale 1ns/1ps
`include "pyr_config.svh"

module pyr_alu (
	input pyr_pkg::word_t a,
	input pyr_pkg::word_t b,
	input pyr_pkg::alu_op_t op,
	output pyr_pkg::word_t result,
	output logic zero,
	output logic neg,
	output logic ltu
);
	import pyr_pkg::*;

	word_t diff;
	logic [3:0] shamt;
	logic a_msb;
	logic b_msb;

	assign diff = a - b;
	// shift amount from low four bits
	assign shamt = b[3:0];
	assign a_msb = a[`PYR_WORD_BITS-1];
	assign b_msb = b[`PYR_WORD_BITS-1];

	//////////////////////////////
	// flags
	//////////////////////////////

	assign zero = (diff == '0);
	// signed less-than is just the sign of the difference
	assign neg = diff[`PYR_WORD_BITS-1];
	assign ltu = (~a_msb & b_msb) | ((a_msb == b_msb) & neg);

	//////////////////////////////
	// result mux
	//////////////////////////////

	always_comb begin
		case (op[2:0])
			F3_ADD:
				result = op[3] ? diff : a + b;
			F3_SLL:
				result = a << shamt;
			// set-less-than returns the flag in bit 0
			F3_SLT:
				result = word_t'(neg);
			F3_SLTU:
				result = word_t'(ltu);
			F3_XOR:
				result = a ^ b;
			F3_SR:
				result = op[3] ? word_t'($signed(a) >>> shamt) : a >> shamt;
			F3_OR:
				result = a | b;
			F3_AND:
				result = a & b;
			default:
				result = '0;
		endcase
	end

endmodule

/* hw/pyr_config.svh */
// Core width settings for the 16-bit pipelined core.
// Included by the package and by any file that sizes logic
// directly from these values.

`ifndef PYR_CONFIG_SVH
`define PYR_CONFIG_SVH

// data path word
`define PYR_WORD_BITS 16
// one instruction word
`define PYR_INSTR_BITS 21
// register file depth and index
`define PYR_NREG 16
`define PYR_REG_BITS 4
// instruction word address, not byte address
`define PYR_PC_BITS 14

`endif

/* hw/pyr_core.sv */
// Top of the pipelined core.
// Fetch, latch, decode and a single execute stage around the register
// file; instruction and data memories hang directly off the ports.

`timescale 1ns/1ps

module pyr_core (
	input logic clk,
	input logic rst,
	input logic run,
	output pyr_pkg::pc_t imem_addr,
	input pyr_pkg::instr_t imem_data,
	output pyr_pkg::word_t dmem_addr,
	output pyr_pkg::word_t dmem_din,
	output logic dmem_we,
	output logic halt
);
	import pyr_pkg::*;

	// fetch to decode
	pc_t if_pc;
	instr_t if_instr;
	logic if_valid;

	// decode to execute and register file
	pc_t id_pc;
	logic id_valid;
	reg_idx_t rs1;
	reg_idx_t rs2;
	reg_idx_t rd;
	logic [2:0] funct3;
	word_t imm;
	alu_op_t alu_op;
	logic use_imm;
	logic is_br;
	logic is_jal;
	logic is_jalr;
	logic is_lui;
	logic is_auipc;
	logic is_store;
	logic is_halt;
	logic writes_rd;

	// register file and redirect
	word_t rs1_data;
	word_t rs2_data;
	logic reg_we;
	word_t reg_wdata;
	logic jump;
	pc_t jump_addr;

	pyr_fetch fetch_i (
		.clk(clk),
		.rst(rst),
		.run(run),
		.jump(jump),
		.jump_addr(jump_addr),
		.imem_addr(imem_addr),
		.imem_data(imem_data),
		.if_pc(if_pc),
		.if_instr(if_instr),
		.if_valid(if_valid)
	);

	pyr_decode decode_i (
		.clk(clk),
		.rst(rst),
		.run(run),
		.if_pc(if_pc),
		.if_instr(if_instr),
		.if_valid(if_valid),
		.id_pc(id_pc),
		.id_valid(id_valid),
		.rs1(rs1),
		.rs2(rs2),
		.rd(rd),
		.funct3(funct3),
		.imm(imm),
		.alu_op(alu_op),
		.use_imm(use_imm),
		.is_br(is_br),
		.is_jal(is_jal),
		.is_jalr(is_jalr),
		.is_lui(is_lui),
		.is_auipc(is_auipc),
		.is_store(is_store),
		.is_halt(is_halt),
		.writes_rd(writes_rd)
	);

	// write index is rd of the instruction in execute
	pyr_regfile regfile_i (
		.clk(clk),
		.rst(rst),
		.run(run),
		.we(reg_we),
		.wr_idx(rd),
		.wr_data(reg_wdata),
		.rs1(rs1),
		.rs2(rs2),
		.rs1_data(rs1_data),
		.rs2_data(rs2_data)
	);

	pyr_execute execute_i (
		.clk(clk),
		.rst(rst),
		.run(run),
		.id_pc(id_pc),
		.id_valid(id_valid),
		.funct3(funct3),
		.imm(imm),
		.alu_op(alu_op),
		.use_imm(use_imm),
		.is_br(is_br),
		.is_jal(is_jal),
		.is_jalr(is_jalr),
		.is_lui(is_lui),
		.is_auipc(is_auipc),
		.is_store(is_store),
		.is_halt(is_halt),
		.writes_rd(writes_rd),
		.rs1_data(rs1_data),
		.rs2_data(rs2_data),
		.reg_we(reg_we),
		.reg_wdata(reg_wdata),
		.jump(jump),
		.jump_addr(jump_addr),
		.dmem_addr(dmem_addr),
		.dmem_din(dmem_din),
		.dmem_we(dmem_we),
		.halt(halt)
	);

endmodule

/* hw/pyr_decode.sv */
// Decode register and field decode.
// Holds the instruction about to execute and splits it into register
// indices, immediate, ALU operation and instruction class flags.

`timescale 1ns/1ps
`include "pyr_config.svh"

module pyr_decode (
	input logic clk,
	input logic rst,
	input logic run,
	input pyr_pkg::pc_t if_pc,
	input pyr_pkg::instr_t if_instr,
	input logic if_valid,
	output pyr_pkg::pc_t id_pc,
	output logic id_valid,
	output pyr_pkg::reg_idx_t rs1,
	output pyr_pkg::reg_idx_t rs2,
	output pyr_pkg::reg_idx_t rd,
	output logic [2:0] funct3,
	output pyr_pkg::word_t imm,
	output pyr_pkg::alu_op_t alu_op,
	output logic use_imm,
	output logic is_br,
	output logic is_jal,
	output logic is_jalr,
	output logic is_lui,
	output logic is_auipc,
	output logic is_store,
	output logic is_halt,
	output logic writes_rd
);
	import pyr_pkg::*;

	instr_t id_instr;
	logic [2:0] opcode;
	logic [2:0] funct7;
	logic is_sys;
	logic is_opimm;
	logic is_op;
	logic itype;
	logic sbtype;
	logic sign;

	//////////////////////////////
	// decode register
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			id_valid <= 1'b0;
			id_instr <= INSTR_BUBBLE;
		end else if (run) begin
			id_valid <= if_valid;
			// squashed or empty slot becomes a bubble
			id_instr <= if_valid ? if_instr : INSTR_BUBBLE;
		end
	end

	always_ff @(posedge clk) begin
		if (run)
			id_pc <= if_pc;
	end

	//////////////////////////////
	// fields and classes
	//////////////////////////////

	assign opcode = id_instr[2:0];
	assign rd = id_instr[6:3];
	assign funct3 = id_instr[9:7];
	assign rs1 = id_instr[13:10];
	assign rs2 = id_instr[17:14];
	assign funct7 = id_instr[20:18];

	assign is_sys = (opcode == OPC_SYS);
	assign is_opimm = (opcode == OPC_OPIMM);
	assign is_op = (opcode == OPC_OP);
	assign is_br = (opcode == OPC_BR);
	assign is_jalr = (opcode == OPC_JALR);
	assign is_auipc = (opcode == OPC_AUIPC);
	assign is_jal = (opcode == OPC_JAL);
	assign is_lui = (opcode == OPC_LUI);
	// funct3 001..011 under sys is a no-op
	assign is_store = is_sys & funct3[2];
	assign is_halt = is_sys & (funct3 == 3'b000);

	assign writes_rd = is_op | is_opimm | is_jal | is_jalr | is_lui | is_auipc;

	//////////////////////////////
	// immediate
	//////////////////////////////

	assign itype = is_opimm | is_jalr;
	assign sbtype = is_store | is_br;
	assign use_imm = itype | is_store;
	assign sign = id_instr[`PYR_INSTR_BITS-1];

	always_comb begin
		if (itype)
			imm = {{(`PYR_WORD_BITS-6){sign}}, id_instr[19:14]};
		else if (sbtype)
			imm = {{(`PYR_WORD_BITS-6){sign}}, id_instr[20:18], id_instr[5:3]};
		else
			// u-type, bit 19 unused
			imm = {{(`PYR_WORD_BITS-12){sign}}, id_instr[18:7]};
	end

	// address forms and auipc all add
	assign alu_op[2:0] = (sbtype | is_auipc | is_jalr) ? F3_ADD : funct3;
	// op: sub and sra, op-imm: shifts only, branch: compare by sub
	assign alu_op[3] = is_br | ((is_op | (is_opimm & funct3[2])) & funct7[1]);

endmodule

/* hw/pyr_execute.sv */
// Execute stage.
// Runs the decoded instruction in one cycle: ALU, branch decision,
// jump target, writeback value, store strobe and the halt flag.

`timescale 1ns/1ps

module pyr_execute (
	input logic clk,
	input logic rst,
	input logic run,
	input pyr_pkg::pc_t id_pc,
	input logic id_valid,
	input logic [2:0] funct3,
	input pyr_pkg::word_t imm,
	input pyr_pkg::alu_op_t alu_op,
	input logic use_imm,
	input logic is_br,
	input logic is_jal,
	input logic is_jalr,
	input logic is_lui,
	input logic is_auipc,
	input logic is_store,
	input logic is_halt,
	input logic writes_rd,
	input pyr_pkg::word_t rs1_data,
	input pyr_pkg::word_t rs2_data,
	output logic reg_we,
	output pyr_pkg::word_t reg_wdata,
	output logic jump,
	output pyr_pkg::pc_t jump_addr,
	output pyr_pkg::word_t dmem_addr,
	output pyr_pkg::word_t dmem_din,
	output logic dmem_we,
	output logic halt
);
	import pyr_pkg::*;

	word_t op_a;
	word_t op_b;
	word_t upper_imm;
	word_t alu_result;
	logic zero;
	logic neg;
	logic ltu;
	logic br_take;

	// lui and auipc immediate sits five bits up
	assign upper_imm = imm << 5;

	/////////////////////////////
	// operands and alu
	/////////////////////////////

	assign op_a = is_auipc ? word_t'(id_pc) : rs1_data;

	always_comb begin
		if (is_auipc)
			op_b = upper_imm;
		else if (use_imm)
			op_b = imm;
		else
			op_b = rs2_data;
	end

	pyr_alu alu_i (
		.a(op_a),
		.b(op_b),
		.op(alu_op),
		.result(alu_result),
		.zero(zero),
		.neg(neg),
		.ltu(ltu)
	);

	/////////////////////////////
	// control flow
	/////////////////////////////

	always_comb begin
		case (funct3)
			F3_BEQ: br_take = zero;
			F3_BNE: br_take = ~zero;
			F3_BLT: br_take = neg;
			F3_BGE: br_take = ~neg;
			F3_BLTU: br_take = ltu;
			F3_BGEU: br_take = ~ltu;
			default: br_take = 1'b0;
		endcase
	end

	assign jump = id_valid & ((is_br & br_take) | is_jal | is_jalr);
	// jalr target is rs1 + imm cut to a word address
	assign jump_addr = is_jalr ? pc_t'(alu_result) : id_pc + pc_t'(imm);

	/////////////////////////////
	// writeback and store
	/////////////////////////////

	always_comb begin
		if (is_lui)
			reg_wdata = upper_imm;
		else if (is_jal | is_jalr)
			// link is the jump's own pc
			reg_wdata = word_t'(id_pc);
		else
			reg_wdata = alu_result;
	end

	assign reg_we = id_valid & run & writes_rd;

	// one-cycle strobe, no back-pressure
	assign dmem_we = id_valid & run & is_store;
	assign dmem_addr = alu_result;
	assign dmem_din = rs2_data;

	// set by halt, cleared by the next valid instruction
	always_ff @(posedge clk) begin
		if (rst)
			halt <= 1'b0;
		else if (run && id_valid)
			halt <= is_halt;
	end

endmodule

/* hw/pyr_fetch.sv */
// Fetch and instruction latch stages.
// Issues one instruction-memory read per running cycle and latches the
// word that comes back a cycle later, together with its address.
// A jump from execute redirects the fetch and kills the two younger slots.

`timescale 1ns/1ps

module pyr_fetch (
	input logic clk,
	input logic rst,
	input logic run,
	input logic jump,
	input pyr_pkg::pc_t jump_addr,
	output pyr_pkg::pc_t imem_addr,
	input pyr_pkg::instr_t imem_data,
	output pyr_pkg::pc_t if_pc,
	output pyr_pkg::instr_t if_instr,
	output logic if_valid
);
	import pyr_pkg::*;

	// next sequential address
	pc_t fetch_pc;
	// address of the read in flight
	pc_t req_pc;
	logic req_valid;
	logic if_valid_q;

	// frozen: replay the in-flight address so imem_data stays put
	always_comb begin
		if (!run)
			imem_addr = req_pc;
		else if (jump)
			imem_addr = jump_addr;
		else
			imem_addr = fetch_pc;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			fetch_pc <= '0;
			req_pc <= '0;
			req_valid <= 1'b0;
			if_valid_q <= 1'b0;
		end else if (run) begin
			req_pc <= imem_addr;
			fetch_pc <= imem_addr + 1'b1;
			// new request always valid, even the jump target
			req_valid <= 1'b1;
			// word returning now belongs to the squashed path
			if_valid_q <= req_valid & ~jump;
		end
	end

	// latch payload
	always_ff @(posedge clk) begin
		if (run) begin
			if_pc <= req_pc;
			if_instr <= imem_data;
		end
	end

	// second younger slot dies before it reaches decode
	assign if_valid = if_valid_q & ~jump;

endmodule

/* hw/pyr_pkg.sv */
// Types and encodings shared by the core stages.
// Modules import this package inside the body and name its types
// with the package scope in their port lists.

`include "pyr_config.svh"

package pyr_pkg;

	//////////////////////////////
	// vector types
	//////////////////////////////

	typedef logic [`PYR_WORD_BITS-1:0] word_t;
	typedef logic [`PYR_PC_BITS-1:0] pc_t;
	typedef logic [`PYR_INSTR_BITS-1:0] instr_t;
	typedef logic [`PYR_REG_BITS-1:0] reg_idx_t;
	// funct3 below, sub/arith modifier on top
	typedef logic [3:0] alu_op_t;

	//////////////////////////////
	// opcodes, bits 2..0
	//////////////////////////////

	// halt and store share this one
	localparam logic [2:0] OPC_SYS = 3'b000;
	localparam logic [2:0] OPC_OPIMM = 3'b001;
	localparam logic [2:0] OPC_BR = 3'b010;
	localparam logic [2:0] OPC_OP = 3'b011;
	localparam logic [2:0] OPC_JALR = 3'b100;
	localparam logic [2:0] OPC_AUIPC = 3'b101;
	localparam logic [2:0] OPC_JAL = 3'b110;
	localparam logic [2:0] OPC_LUI = 3'b111;

	// dead slot in the decode register
	localparam instr_t INSTR_BUBBLE = '1;

	// alu funct3
	localparam logic [2:0] F3_ADD = 3'b000;
	localparam logic [2:0] F3_SLL = 3'b001;
	localparam logic [2:0] F3_SLT = 3'b010;
	localparam logic [2:0] F3_SLTU = 3'b011;
	localparam logic [2:0] F3_XOR = 3'b100;
	localparam logic [2:0] F3_SR = 3'b101;
	localparam logic [2:0] F3_OR = 3'b110;
	localparam logic [2:0] F3_AND = 3'b111;

	// branch funct3, 010 and 011 never taken
	localparam logic [2:0] F3_BEQ = 3'b000;
	localparam logic [2:0] F3_BNE = 3'b001;
	localparam logic [2:0] F3_BLT = 3'b100;
	localparam logic [2:0] F3_BGE = 3'b101;
	localparam logic [2:0] F3_BLTU = 3'b110;
	localparam logic [2:0] F3_BGEU = 3'b111;

endpackage

/* hw/pyr_regfile.sv */
// General purpose register file.
// Two combinational read ports and one write port; register 0
// always reads as zero whatever was written to it.

`timescale 1ns/1ps
`include "pyr_config.svh"

module pyr_regfile (
	input logic clk,
	input logic rst,
	input logic run,
	input logic we,
	input pyr_pkg::reg_idx_t wr_idx,
	input pyr_pkg::word_t wr_data,
	input pyr_pkg::reg_idx_t rs1,
	input pyr_pkg::reg_idx_t rs2,
	output pyr_pkg::word_t rs1_data,
	output pyr_pkg::word_t rs2_data
);
	import pyr_pkg::*;

	word_t regs [`PYR_NREG];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `PYR_NREG; i++)
				regs[i] <= '0;
		end else if (run && we) begin
			regs[wr_idx] <= wr_data;
		end
	end

	assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
	assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

/* project.f */
+incdir+hw
hw/pyr_pkg.sv
hw/pyr_alu.sv
hw/pyr_regfile.sv
hw/pyr_fetch.sv
hw/pyr_decode.sv
hw/pyr_execute.sv
hw/pyr_core.sv
verification/pyr_core_tb.sv

/* verification/pyr_core_tb.sv */
// Directed testbench for the pipelined core.
// Each test builds a small program in the instruction ROM model, resets the
// core and checks the stores and the halt flag against a reference model.

`timescale 1ns/1ps
`include "pyr_config.svh"

module pyr_core_tb;
	import pyr_pkg::*;

	localparam int TEST_CYCLES = 300;
	localparam int CYCLE_LIMIT = 5 * TEST_CYCLES;

	logic clk;
	logic rst;
	logic run;
	pc_t imem_addr;
	instr_t imem_data;
	word_t dmem_addr;
	word_t dmem_din;
	logic dmem_we;
	logic halt;

	instr_t rom [256];
	instr_t prog [$];
	word_t st_addr_q [$];
	word_t st_data_q [$];
	word_t exp_addr_q [$];
	word_t exp_data_q [$];
	logic [31:0] rng;
	int cycles;
	int errors;
	int tests_run;
	int tests_failed;
	int test_err_start;

	pyr_core pyr_core_i (
		.clk(clk),
		.rst(rst),
		.run(run),
		.imem_addr(imem_addr),
		.imem_data(imem_data),
		.dmem_addr(dmem_addr),
		.dmem_din(dmem_din),
		.dmem_we(dmem_we),
		.halt(halt)
	);

	always #10 clk = ~clk;

	// registered rom read with one cycle of latency
	always @(posedge clk)
		imem_data <= rom[imem_addr[7:0]];

	// store monitor
	always @(posedge clk) begin
		if (dmem_we) begin
			st_addr_q.push_back(dmem_addr);
			st_data_q.push_back(dmem_din);
		end
	end

	// run limit
	always @(posedge clk) begin
		cycles++;
		if (cycles >= CYCLE_LIMIT) begin
			$display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("Test FAILED");
			$finish;
		end
	end

	//////////////////////////////
	// encoders
	//////////////////////////////

	function automatic instr_t enc_r(input logic [2:0] f7, input reg_idx_t rs2,
			input reg_idx_t rs1, input logic [2:0] f3, input reg_idx_t rd,
			input logic [2:0] op);
		return {f7, rs2, rs1, f3, rd, op};
	endfunction

	// imm must fit -64..63
	function automatic instr_t enc_i(input word_t imm, input reg_idx_t rs1,
			input logic [2:0] f3, input reg_idx_t rd, input logic [2:0] op);
		return {imm[15], imm[5:0], rs1, f3, rd, op};
	endfunction

	// store and branch offsets within -32..31
	function automatic instr_t enc_s(input word_t imm, input reg_idx_t rs2,
			input reg_idx_t rs1, input logic [2:0] f3, input logic [2:0] op);
		return {imm[5:3], rs2, rs1, f3, 1'b0, imm[2:0], op};
	endfunction

	function automatic instr_t enc_u(input word_t imm, input reg_idx_t rd,
			input logic [2:0] op);
		return {imm[15], 1'b0, imm[11:0], rd, op};
	endfunction

	function automatic instr_t store_to(input reg_idx_t rs2, input word_t addr);
		return enc_s(addr, rs2, 4'd0, 3'b100, OPC_SYS);
	endfunction

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	//////////////////////////////
	// reference model
	//////////////////////////////

	function automatic word_t alu_ref(input logic [2:0] f3, input logic mod,
			input word_t a, input word_t b);
		word_t d;
		d = a - b;
		case (f3)
			3'd0: return mod ? d : a + b;
			3'd1: return a << b[3:0];
			// signed compare is the sign of the difference
			3'd2: return {15'b0, d[15]};
			3'd3: return (a < b) ? 16'd1 : 16'd0;
			3'd4: return a ^ b;
			3'd5: return mod ? word_t'($signed(a) >>> b[3:0]) : a >> b[3:0];
			3'd6: return a | b;
			default: return a & b;
		endcase
	endfunction

	function automatic logic br_ref(input logic [2:0] f3, input word_t a, input word_t b);
		word_t d;
		d = a - b;
		case (f3)
			3'b000: return a == b;
			3'b001: return a != b;
			3'b100: return d[15];
			3'b101: return !d[15];
			3'b110: return a < b;
			3'b111: return a >= b;
			default: return 1'b0;
		endcase
	endfunction

	//////////////////////////////
	// checks and helpers
	//////////////////////////////

	task automatic check_word(input string name, input word_t exp, input word_t act);
		if (exp !== act) begin
			errors++;
			$display("Error at %0t: %s expected %h got %h", $time, name, exp, act);
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (exp !== act) begin
			errors++;
			$display("Error at %0t: %s expected %b got %b", $time, name, exp, act);
		end
	endtask

	task automatic emit(input instr_t w);
		prog.push_back(w);
	endtask

	// lui sets the upper eleven bits and addi the low five
	task automatic load_const(input reg_idx_t rd, input word_t v);
		emit(enc_u({5'b0, v[15:5]}, rd, OPC_LUI));
		emit(enc_i({11'b0, v[4:0]}, rd, 3'b000, rd, OPC_OPIMM));
	endtask

	task automatic expect_store(input word_t addr, input word_t data);
		exp_addr_q.push_back(addr);
		exp_data_q.push_back(data);
	endtask

	// unused words are no-ops tagged with their address
	task automatic start_prog;
		for (int i = 0; i < 256; i++)
			rom[i] = {3'b0, i[7:0], 3'b001, 4'd0, OPC_SYS};
		// spin at the end
		emit(enc_u(16'd0, 4'd0, OPC_JAL));
		for (int i = 0; i < prog.size(); i++)
			rom[i] = prog[i];
		st_addr_q.delete();
		st_data_q.delete();
		test_err_start = errors;
		rst = 1'b1;
		run = 1'b1;
		repeat (8) @(negedge clk);
		rst = 1'b0;
	endtask

	task automatic wait_stores(input int n);
		int k;
		k = 0;
		while (st_addr_q.size() < n && k < TEST_CYCLES) begin
			@(negedge clk);
			k++;
		end
		// room for stray stores
		repeat (20) @(negedge clk);
	endtask

	task automatic compare_stores;
		int n;
		n = exp_addr_q.size();
		if (st_addr_q.size() != n) begin
			errors++;
			$display("expected %0d stores but saw %0d", n, st_addr_q.size());
		end
		for (int i = 0; i < n && i < st_addr_q.size(); i++) begin
			check_word("dmem_addr", exp_addr_q[i], st_addr_q[i]);
			check_word("dmem_din", exp_data_q[i], st_data_q[i]);
		end
	endtask

	task automatic finish_test(input string name);
		tests_run++;
		if (errors != test_err_start)
			tests_failed++;
		$display("%s: %s, %0d errors", name,
			(errors == test_err_start) ? "passed" : "failed", errors - test_err_start);
		prog.delete();
		exp_addr_q.delete();
		exp_data_q.delete();
	endtask

	//////////////////////////////
	// tests
	//////////////////////////////

	task automatic test_alu;
		word_t a;
		word_t b;
		word_t imm;
		logic [2:0] f3s [10] = '{0, 0, 1, 2, 3, 4, 5, 5, 6, 7};
		logic mods [10] = '{0, 1, 0, 0, 0, 0, 0, 1, 0, 0};
		logic [2:0] if3 [4] = '{3'd0, 3'd4, 3'd5, 3'd2};
		rng = xorshift(rng);
		a = rng[15:0];
		rng = xorshift(rng);
		b = rng[15:0];
		load_const(4'd1, a);
		load_const(4'd2, b);
		for (int i = 0; i < 10; i++) begin
			emit(enc_r({1'b0, mods[i], 1'b0}, 4'd2, 4'd1, f3s[i], 4'd3, OPC_OP));
			emit(store_to(4'd3, word_t'(i)));
			expect_store(word_t'(i), alu_ref(f3s[i], mods[i], a, b));
		end
		// addi, xori, srai, slti
		for (int i = 0; i < 4; i++) begin
			rng = xorshift(rng);
			if (if3[i] == 3'd5)
				imm = {10'b0, 2'b10, rng[3:0]};
			else
				imm = {{9{rng[6]}}, rng[6:0]};
			emit(enc_i(imm, 4'd1, if3[i], 4'd3, OPC_OPIMM));
			emit(store_to(4'd3, word_t'(10 + i)));
			expect_store(word_t'(10 + i), alu_ref(if3[i], (if3[i] == 3'd5) & imm[5], a, imm));
		end
		start_prog();
		wait_stores(14);
		compare_stores();
		finish_test("alu");
	endtask

	task automatic test_upper;
		word_t u1;
		word_t u2;
		int auipc_pc;
		rng = xorshift(rng);
		u1 = {5'b0, rng[10:0]};
		u2 = {5'b0, rng[26:16]};
		emit(enc_u(u1, 4'd3, OPC_LUI));
		emit(store_to(4'd3, 16'd1));
		auipc_pc = prog.size();
		emit(enc_u(u2, 4'd4, OPC_AUIPC));
		emit(store_to(4'd4, 16'd2));
		expect_store(16'd1, u1 << 5);
		expect_store(16'd2, word_t'(auipc_pc) + (u2 << 5));
		start_prog();
		wait_stores(2);
		compare_stores();
		finish_test("lui/auipc");
	endtask

	task automatic test_branch;
		word_t vals [5] = '{16'd0, 16'd5, 16'd5, 16'hfffd, 16'd7};
		logic [2:0] f3s [6] = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
		// operand register pairs for both outcomes
		reg_idx_t ra [2] = '{4'd1, 4'd4};
		reg_idx_t rb [2] = '{4'd2, 4'd3};
		reg_idx_t x;
		reg_idx_t y;
		int c;
		int base;
		emit(enc_i(16'd5, 4'd0, 3'b000, 4'd1, OPC_OPIMM));
		emit(enc_i(16'd5, 4'd0, 3'b000, 4'd2, OPC_OPIMM));
		emit(enc_i(16'hfffd, 4'd0, 3'b000, 4'd3, OPC_OPIMM));
		emit(enc_i(16'd7, 4'd0, 3'b000, 4'd4, OPC_OPIMM));
		c = 0;
		for (int f = 0; f < 6; f++) begin
			for (int p = 0; p < 4; p++) begin
				// mix equal, swapped and cross pairs
				x = (p < 2) ? ra[p] : rb[p - 2];
				y = (p < 2) ? rb[p] : ra[p - 2];
				// marker addresses sit around zero within the store offset range
				base = 2 * c - 24;
				emit(enc_s(16'd3, y, x, f3s[f], OPC_BR));
				emit(store_to(4'd0, word_t'(base)));
				emit(enc_u(16'd2, 4'd0, OPC_JAL));
				emit(store_to(4'd0, word_t'(base + 1)));
				expect_store(word_t'(base + br_ref(f3s[f], vals[x], vals[y])), 16'd0);
				c++;
			end
		end
		start_prog();
		wait_stores(c);
		compare_stores();
		finish_test("branch");
	endtask

	task automatic test_jump;
		emit(enc_i(16'd8, 4'd0, 3'b000, 4'd1, OPC_OPIMM));
		// jal at 1 to 5
		emit(enc_u(16'd4, 4'd5, OPC_JAL));
		emit(store_to(4'd0, 16'd30));
		emit(store_to(4'd0, 16'd30));
		emit(store_to(4'd0, 16'd30));
		// jalr at 5 to x1 + 2
		emit(enc_i(16'd2, 4'd1, 3'b000, 4'd6, OPC_JALR));
		emit(store_to(4'd0, 16'd31));
		emit(store_to(4'd0, 16'd31));
		emit(store_to(4'd0, 16'd31));
		emit(store_to(4'd0, 16'd31));
		emit(store_to(4'd5, 16'd1));
		emit(store_to(4'd6, 16'd2));
		expect_store(16'd1, 16'd1);
		expect_store(16'd2, 16'd5);
		start_prog();
		wait_stores(2);
		compare_stores();
		finish_test("jal/jalr");
	endtask

	task automatic test_halt;
		word_t v;
		int k;
		rng = xorshift(rng);
		v = {11'b0, rng[4:0]};
		emit(enc_i(v, 4'd0, 3'b000, 4'd1, OPC_OPIMM));
		emit(21'd0);
		emit(store_to(4'd1, 16'd7));
		expect_store(16'd7, v);
		start_prog();
		check_bit("halt", 1'b0, halt);
		k = 0;
		while (halt !== 1'b1 && k < TEST_CYCLES) begin
			@(negedge clk);
			k++;
		end
		// freeze while the store sits in execute
		run = 1'b0;
		check_bit("halt", 1'b1, halt);
		repeat (20) begin
			@(negedge clk);
			check_bit("halt", 1'b1, halt);
			if (st_addr_q.size() != 0) begin
				errors++;
				$display("a store appeared while run was low");
			end
		end
		run = 1'b1;
		wait_stores(1);
		check_bit("halt", 1'b0, halt);
		compare_stores();
		finish_test("halt/run");
	endtask

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		run = 1'b1;
		imem_data = '0;
		rng = 32'he8df;
		cycles = 0;
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		test_err_start = 0;
		test_alu();
		test_upper();
		test_branch();
		test_jump();
		test_halt();
		$display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule
